//--- design/cart_pkg.sv
// Cartridge mapper shared definitions
package cart_pkg;

	// ****************************************
	// Widths and constants
	// ****************************************
	localparam int CPU_AW   = 16;                  // CPU address bus
	localparam int SDRAM_AW = 25;                  // Translated address
	localparam int BANK_W   = 7;                   // Up to 128 banks of 8K
	localparam int BANK_LSB = 13;                  // Bank number starts here
	localparam int BASE_W   = SDRAM_AW - BANK_LSB; // Bank part of the SDRAM address
	localparam int TIMER_W  = 16;

	// ROM bank 0 sits at 0x100000
	localparam logic [BASE_W-1:0]  ROM_BASE_BANK   = 12'd128;
	localparam logic [TIMER_W-1:0] FASTLOAD_CYCLES = 16'd16384; // Epyx discharge time

	typedef logic [CPU_AW-1:0]   cpu_addr_t;
	typedef logic [SDRAM_AW-1:0] sdram_addr_t;
	typedef logic [BANK_W-1:0]   bank_t;

	// ****************************************
	// Cartridge types and port modes
	// ****************************************
	typedef enum logic [15:0] {
		CART_GENERIC    = 16'd0,
		CART_SIMONS     = 16'd4,
		CART_OCEAN      = 16'd5,
		CART_EPYX       = 16'd10,
		CART_MAGIC_DESK = 16'd19
	} cart_type_e;

	// Encoded as {exrom, game}
	typedef enum logic [1:0] {
		MODE_16K     = 2'b00,
		MODE_8K      = 2'b01,
		MODE_ULTIMAX = 2'b10,
		MODE_OFF     = 2'b11
	} mem_mode_e;

	// ****************************************
	// Bus and config bundles
	// ****************************************
	typedef struct packed {
		logic      rom_l;     // ROML select
		logic      rom_h;     // ROMH select
		logic      ioe;       // $DExx page
		logic      iof;       // $DFxx page
		logic      mem_write;
		cpu_addr_t addr;
	} cpu_bus_t;

	// One-cycle access strobes
	typedef struct packed {
		logic ioe_wr;
		logic ioe_rd;
		logic iof_wr;
	} io_cycle_t;

	typedef struct packed {
		bank_t     bank_lo;   // Bank behind ROML
		bank_t     bank_hi;   // Bank behind ROMH
		mem_mode_e mode;
	} cart_cfg_t;

endpackage

//--- design/io_strobe.sv
// IOE and IOF access strobes
module io_strobe import cart_pkg::*; (
	input  logic      clk32,
	input  logic      reset_n,
	input  cpu_bus_t  bus,
	output io_cycle_t strobes
);

	logic old_ioe;   // Page select seen last cycle
	logic old_iof;
	logic stb_ioe;
	logic stb_iof;

	always_ff @(posedge clk32) begin
		if (reset_n) begin
			// Treat the lines as already high so a held select is not an access
			old_ioe <= 1'b1;
			old_iof <= 1'b1;
		end else begin
			old_ioe <= bus.ioe;
			old_iof <= bus.iof;
		end
	end

	// First cycle of a select only
	assign stb_ioe = bus.ioe & ~old_ioe;
	assign stb_iof = bus.iof & ~old_iof;

	// Split by direction
	assign strobes.ioe_wr = stb_ioe & bus.mem_write;
	assign strobes.ioe_rd = stb_ioe & ~bus.mem_write;
	assign strobes.iof_wr = stb_iof & bus.mem_write;

endmodule

//--- design/fastload_timer.sv
// Epyx Fastload discharge timer
module fastload_timer import cart_pkg::*; (
	input  logic clk32,
	input  logic reset_n,
	input  logic start,     // Epyx mapping active
	input  logic reload,    // Capacitor charged by an access
	output logic expired
);

	logic [TIMER_W-1:0] count;
	logic               running;   // Charged at least once

	// ****************************************
	// Down-counter
	// ****************************************
	always_ff @(posedge clk32) begin
		if (reset_n || !start) begin
			count   <= '0;
			running <= 1'b0;          // Idle until the first access
		end else if (reload) begin
			count   <= FASTLOAD_CYCLES;
			running <= 1'b1;
		end else if (running && (count != '0)) begin
			count   <= count - 1'b1;  // Holds at zero
		end
	end

	// Capacitor drained
	assign expired = running && (count == '0);

endmodule

//--- design/mapper_control.sv
// Cartridge bank and mode control
module mapper_control import cart_pkg::*; (
	input  logic       clk32,
	input  logic       reset_n,
	input  cart_type_e cart_id,
	input  logic       cart_exrom,    // EXROM level from the CRT header
	input  logic       cart_game,     // GAME level from the CRT header
	input  io_cycle_t  strobes,
	input  cpu_bus_t   bus,
	input  logic       expired,
	output logic       timer_start,
	output logic       timer_reload,
	output cart_cfg_t  cfg
);

	cart_type_e old_id;      // Type seen last cycle
	logic       init_pend;   // Per-type initial values due
	logic       id_change;
	logic [7:0] data;        // CPU data byte

	assign id_change = (cart_id != old_id);

	// Register writes carry their value on the low address byte
	assign data = bus.addr[7:0];

	// ****************************************
	// Epyx timer control
	// ****************************************
	assign timer_start  = (cart_id == CART_EPYX) && !init_pend;
	assign timer_reload = (cart_id == CART_EPYX) && (bus.ioe || bus.rom_l);

	// ****************************************
	// Per-type registers
	// ****************************************
	always_ff @(posedge clk32) begin
		old_id    <= cart_id;
		init_pend <= 1'b0;

		if (reset_n || id_change) begin
			// Cartridge off the bus for one cycle
			init_pend   <= 1'b1;
			cfg.mode    <= MODE_OFF;
			cfg.bank_lo <= '0;
			cfg.bank_hi <= '0;
		end else begin
			case (cart_id)

				// Plain ROM, lines straight from the header
				CART_GENERIC: begin
					cfg.mode    <= mem_mode_e'({cart_exrom, cart_game});
					cfg.bank_lo <= '0;
					cfg.bank_hi <= 7'd1;
				end

				// Simons Basic
				// IOE read drops to 8K, IOE write back to 16K
				CART_SIMONS: begin
					if (init_pend) begin
						cfg.mode    <= MODE_16K;
						cfg.bank_lo <= '0;
						cfg.bank_hi <= 7'd1;
					end else if (strobes.ioe_wr) begin
						cfg.mode <= MODE_16K;
					end else if (strobes.ioe_rd) begin
						cfg.mode <= MODE_8K;
					end
				end

				// Ocean type 1, same bank mirrored at $8000 and $A000
				CART_OCEAN: begin
					cfg.mode <= MODE_16K;
					if (strobes.ioe_wr) begin
						cfg.bank_lo <= {1'b0, data[5:0]};
						cfg.bank_hi <= {1'b0, data[5:0]};
					end
				end

				// Epyx Fastload
				// Any ROML or IOE access recharges the capacitor
				CART_EPYX: begin
					cfg.bank_lo <= '0;
					if (init_pend || bus.ioe || bus.rom_l) begin
						cfg.mode <= MODE_8K;
					end else if (expired) begin
						cfg.mode <= MODE_OFF;      // Discharged, cart drops out
					end
				end

				// Magic Desk, up to 128 banks
				CART_MAGIC_DESK: begin
					if (init_pend) begin
						cfg.mode    <= MODE_8K;
						cfg.bank_lo <= '0;
					end else if (strobes.ioe_wr) begin
						cfg.bank_lo <= data[6:0];
						cfg.mode    <= data[7] ? MODE_OFF : MODE_8K; // Bit 7 hides the cart
					end
				end

				default: begin
					cfg.mode <= MODE_OFF;   // Unsupported type
				end

			endcase
		end
	end

endmodule

//--- design/addr_translate.sv
// Port line decode and SDRAM address mapping
module addr_translate import cart_pkg::*; (
	input  cart_cfg_t   cfg,
	input  cpu_bus_t    bus,
	output logic        exrom,
	output logic        game,
	output logic        mem_write_out,
	output sdram_addr_t addr_out
);

	// SDRAM page of a ROM bank
	function automatic logic [BASE_W-1:0] rom_page(input bank_t bank);
		logic [BASE_W-1:0] wide;
		wide     = {{(BASE_W-BANK_W){1'b0}}, bank};
		rom_page = ROM_BASE_BANK + wide;
	endfunction

	// Mode encoding is the line pair itself
	assign {exrom, game} = cfg.mode;

	assign mem_write_out = bus.mem_write;

	// ****************************************
	// Address translation
	// ****************************************
	always_comb begin
		// Everything else goes through untouched
		addr_out = {{(SDRAM_AW-CPU_AW){1'b0}}, bus.addr};

		if (bus.rom_l && !bus.mem_write) begin
			addr_out[SDRAM_AW-1:BANK_LSB] = rom_page(cfg.bank_lo);  // $8000-$9FFF
		end else if (bus.rom_h && !bus.mem_write) begin
			addr_out[SDRAM_AW-1:BANK_LSB] = rom_page(cfg.bank_hi);  // $A000 or $E000
		end
	end

endmodule

//--- design/cart_top.sv
// C64 cartridge mapper top level
module cart_top import cart_pkg::*; (
	input  logic        clk32,
	input  logic        reset_n,
	input  cpu_bus_t    bus,
	input  cart_type_e  cart_id,
	input  logic        cart_exrom,
	input  logic        cart_game,
	output logic        exrom,
	output logic        game,
	output logic        mem_write_out,
	output sdram_addr_t addr_out
);

	io_cycle_t strobes;
	cart_cfg_t cfg;
	logic      timer_start;
	logic      timer_reload;
	logic      expired;

	io_strobe u_io_strobe (
		.clk32   (clk32),
		.reset_n (reset_n),
		.bus     (bus),
		.strobes (strobes)
	);

	mapper_control u_mapper_control (
		.clk32        (clk32),
		.reset_n      (reset_n),
		.cart_id      (cart_id),
		.cart_exrom   (cart_exrom),
		.cart_game    (cart_game),
		.strobes      (strobes),
		.bus          (bus),
		.expired      (expired),
		.timer_start  (timer_start),
		.timer_reload (timer_reload),
		.cfg          (cfg)
	);

	fastload_timer u_fastload_timer (
		.clk32   (clk32),
		.reset_n (reset_n),
		.start   (timer_start),
		.reload  (timer_reload),
		.expired (expired)
	);

	addr_translate u_addr_translate (
		.cfg           (cfg),
		.bus           (bus),
		.exrom         (exrom),
		.game          (game),
		.mem_write_out (mem_write_out),
		.addr_out      (addr_out)
	);

endmodule

//--- bench/cart_sva.sv
// Cartridge mapper bound assertions
module cart_sva import cart_pkg::*; (
	input logic        clk32,
	input logic        reset_n,
	input cpu_bus_t    bus,
	input io_cycle_t   strobes,
	input logic        exrom,
	input logic        game,
	input logic        mem_write_out,
	input sdram_addr_t addr_out
);

	timeunit 1ns;
	timeprecision 100ps;

	// ****************************************
	// Port lines
	// ****************************************
	// Cartridge is off the bus right after a reset cycle
	reset_lines_high: assert property (@(posedge clk32) reset_n |=> (exrom && game))
		else $error("exrom and game not both high after reset");

	// ****************************************
	// Access strobes
	// ****************************************
	strobe_one_cycle: assert property (@(posedge clk32) disable iff (reset_n)
		(strobes != '0) |=> ((strobes & $past(strobes)) == '0))
		else $error("IO strobe held for two cycles");

	// ****************************************
	// Address path
	// ****************************************
	// Only ROM reads reach the 1 MB region
	rom_region_select: assert property (@(posedge clk32) disable iff (reset_n)
		addr_out[20] |-> (bus.rom_l || bus.rom_h))
		else $error("addr_out bit 20 set without a ROM select");

	write_passthrough: assert property (@(posedge clk32)
		mem_write_out == bus.mem_write)
		else $error("mem_write_out differs from mem_write");

endmodule

//--- bench/cart_tb.sv
// Cartridge mapper testbench
module cart_tb import cart_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD = 4;

	typedef enum logic [1:0] {ACC_NONE, ACC_IOE_RD, ACC_IOE_WR} access_e;

	// One row of the stimulus table
	typedef struct packed {
		cart_type_e  ctype;
		logic        hdr_exrom;   // CRT header lines
		logic        hdr_game;
		access_e     access;
		logic [7:0]  data;
		cpu_addr_t   probe_addr;
		logic        probe_l;
		logic        probe_h;
		logic        exp_exrom;
		logic        exp_game;
		sdram_addr_t exp_addr;
	} step_t;

	logic        clk32;
	logic        reset_n;
	cpu_bus_t    bus;
	cart_type_e  cart_id;
	logic        cart_exrom;
	logic        cart_game;
	logic        exrom;
	logic        game;
	logic        mem_write_out;
	sdram_addr_t addr_out;

	step_t       steps[$];
	logic [31:0] rng_state;
	int          test_count;
	int          fail_count;
	logic        test_bad;

	initial clk32 = 1'b0;
	always #(PERIOD / 2) clk32 = ~clk32;

	cart_top uut (
		.clk32         (clk32),
		.reset_n       (reset_n),
		.bus           (bus),
		.cart_id       (cart_id),
		.cart_exrom    (cart_exrom),
		.cart_game     (cart_game),
		.exrom         (exrom),
		.game          (game),
		.mem_write_out (mem_write_out),
		.addr_out      (addr_out)
	);

	bind cart_top cart_sva u_sva (
		.clk32         (clk32),
		.reset_n       (reset_n),
		.bus           (bus),
		.strobes       (strobes),
		.exrom         (exrom),
		.game          (game),
		.mem_write_out (mem_write_out),
		.addr_out      (addr_out)
	);

	// ****************************************
	// Reference rules
	// ****************************************
	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// ROM bank n lives at 1 MB plus n times 8K
	function automatic sdram_addr_t rom_addr(input int bank, input cpu_addr_t addr);
		int flat;
		flat = 32'h100000 + bank * 32'h2000 + int'(addr[12:0]);
		return sdram_addr_t'(flat);
	endfunction

	// {exrom, game} right after the switch to a type
	function automatic logic [1:0] init_lines(input cart_type_e ctype, input logic hx,
			input logic hg);
		case (ctype)
			CART_GENERIC:    return {hx, hg};
			CART_SIMONS,
			CART_OCEAN:      return 2'b00;   // 16K
			CART_EPYX,
			CART_MAGIC_DESK: return 2'b01;   // 8K
			default:         return 2'b11;
		endcase
	endfunction

	task automatic add_step(input cart_type_e ctype, input logic [1:0] hdr, input access_e access,
			input logic [7:0] data, input cpu_addr_t probe_addr, input logic [1:0] probe_lh,
			input logic [1:0] lines, input sdram_addr_t exp_addr);
		step_t s;
		s.ctype      = ctype;
		{s.hdr_exrom, s.hdr_game} = hdr;
		s.access     = access;
		s.data       = data;
		s.probe_addr = probe_addr;
		{s.probe_l, s.probe_h}    = probe_lh;
		{s.exp_exrom, s.exp_game} = lines;
		s.exp_addr   = exp_addr;
		steps.push_back(s);
	endtask

	// ****************************************
	// Drive and check helpers
	// ****************************************
	task automatic next_cycle();
		@(posedge clk32);
		#1;                              // Drive point
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
			test_bad = 1'b1;
		end
	endtask

	task automatic check_addr(input string name, input sdram_addr_t got, input sdram_addr_t exp);
		assert (got === exp) else begin
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
			test_bad = 1'b1;
		end
	endtask

	task automatic finish_test(input string label);
		test_count++;
		if (test_bad) begin
			fail_count++;
			$display("test %0d %s: FAILED", test_count, label);
		end else begin
			$display("test %0d %s: ok", test_count, label);
		end
		test_bad = 1'b0;
	endtask

	// Lines go high for one cycle, then the new type's initial mode
	task automatic change_type(input step_t s);
		logic [1:0] lines;
		lines = init_lines(s.ctype, s.hdr_exrom, s.hdr_game);
		next_cycle();
		bus        = '0;
		cart_id    = s.ctype;
		cart_exrom = s.hdr_exrom;
		cart_game  = s.hdr_game;
		next_cycle();
		#2;
		check_bit("exrom", exrom, 1'b1);
		check_bit("game", game, 1'b1);
		next_cycle();
		#2;
		check_bit("exrom", exrom, lines[1]);
		check_bit("game", game, lines[0]);
	endtask

	task automatic run_step(input step_t s);
		if (s.ctype != cart_id) begin
			change_type(s);
		end
		next_cycle();
		bus        = '0;
		cart_exrom = s.hdr_exrom;
		cart_game  = s.hdr_game;
		next_cycle();
		if (s.access != ACC_NONE) begin
			bus.ioe       = 1'b1;   // Register access in $DExx
			bus.mem_write = (s.access == ACC_IOE_WR);
			bus.addr      = {8'hde, s.data};
			#2;
			check_bit("mem_write_out", mem_write_out, s.access == ACC_IOE_WR);
			next_cycle();
			next_cycle();
		end
		bus       = '0;
		bus.rom_l = s.probe_l;
		bus.rom_h = s.probe_h;
		bus.addr  = s.probe_addr;
		#2;
		check_bit("exrom", exrom, s.exp_exrom);
		check_bit("game", game, s.exp_game);
		check_bit("mem_write_out", mem_write_out, 1'b0);
		check_addr("addr_out", addr_out, s.exp_addr);
	endtask

	// ****************************************
	// Epyx capacitor discharge
	// ****************************************
	task automatic epyx_discharge();
		int   cycles;
		logic rose;
		next_cycle();
		bus       = '0;
		bus.rom_l = 1'b1;            // One ROML read recharges
		bus.addr  = 16'h8000;
		next_cycle();
		bus    = '0;
		cycles = 0;
		rose   = 1'b0;
		while (!rose && (cycles <= int'(FASTLOAD_CYCLES) + 10)) begin
			#2;
			if (exrom) begin
				rose = 1'b1;
			end else begin
				cycles++;
				next_cycle();
			end
		end
		if (!rose) begin
			$display("Timeout: exrom still low %0d cycles after the last ROML access", cycles);
			test_bad = 1'b1;
		end else begin
			assert (cycles >= int'(FASTLOAD_CYCLES)) else begin
				$display("Epyx cartridge dropped out after only %0d cycles", cycles);
				test_bad = 1'b1;
			end
		end
		check_bit("game", game, 1'b1);
		finish_test("epyx discharge");

		next_cycle();
		bus.ioe  = 1'b1;
		bus.addr = 16'hde00;
		next_cycle();
		next_cycle();
		bus = '0;
		#2;
		check_bit("exrom", exrom, 1'b0);     // Back in 8K
		check_bit("game", game, 1'b1);
		finish_test("epyx recharge");
	endtask

	// ****************************************
	// Main sequence
	// ****************************************
	initial begin
		logic [31:0] r;
		cpu_addr_t   off;
		logic [7:0]  d;
		cart_type_e  t;

		reset_n    = 1'b1;
		bus        = '0;
		cart_id    = CART_GENERIC;
		cart_exrom = 1'b1;
		cart_game  = 1'b1;
		rng_state  = 32'hd08ad949;
		test_count = 0;
		fail_count = 0;
		test_bad   = 1'b0;

		// Generic, one row per header pair plus a plain pass-through
		r   = lcg_next();
		off = {3'b000, r[28:16]};
		add_step(CART_GENERIC, 2'b01, ACC_NONE, 8'h00, 16'h8000 | off, 2'b10, 2'b01,
			rom_addr(0, off));
		add_step(CART_GENERIC, 2'b00, ACC_NONE, 8'h00, 16'ha000 | off, 2'b01, 2'b00,
			rom_addr(1, off));
		add_step(CART_GENERIC, 2'b10, ACC_NONE, 8'h00, 16'he000 | off, 2'b01, 2'b10,
			rom_addr(1, off));
		r = lcg_next();
		add_step(CART_GENERIC, 2'b10, ACC_NONE, 8'h00, r[31:16], 2'b00, 2'b10,
			sdram_addr_t'(r[31:16]));

		// Ocean, both ROM windows follow the written bank
		for (int i = 0; i < 3; i++) begin
			r   = lcg_next();
			d   = r[31:24];
			off = {3'b000, r[20:8]};
			add_step(CART_OCEAN, 2'b11, ACC_IOE_WR, d, (i[0] ? 16'ha000 : 16'h8000) | off,
				i[0] ? 2'b01 : 2'b10, 2'b00, rom_addr(int'(d[5:0]), off));
		end

		// Magic Desk, bit 7 hides the cartridge
		for (int i = 0; i < 3; i++) begin
			r   = lcg_next();
			d   = (i == 1) ? (r[31:24] | 8'h80) : (r[31:24] & 8'h7f);
			off = {3'b000, r[20:8]};
			add_step(CART_MAGIC_DESK, 2'b11, ACC_IOE_WR, d, 16'h8000 | off, 2'b10,
				d[7] ? 2'b11 : 2'b01, rom_addr(int'(d[6:0]), off));
		end

		// Simons Basic, read and write alternate
		for (int i = 0; i < 4; i++) begin
			r   = lcg_next();
			off = {3'b000, r[28:16]};
			if (i[0]) begin
				add_step(CART_SIMONS, 2'b11, ACC_IOE_WR, 8'h00, 16'ha000 | off, 2'b01,
					2'b00, rom_addr(1, off));
			end else begin
				add_step(CART_SIMONS, 2'b11, ACC_IOE_RD, 8'h00, 16'h8000 | off, 2'b10,
					2'b01, rom_addr(0, off));
			end
		end

		r   = lcg_next();
		off = {3'b000, r[28:16]};
		add_step(CART_EPYX, 2'b11, ACC_NONE, 8'h00, 16'h8000 | off, 2'b10, 2'b01,
			rom_addr(0, off));

		// Reset for two cycles
		repeat (2) @(posedge clk32);
		#1;
		reset_n = 1'b0;
		#2;
		check_bit("exrom", exrom, 1'b1);
		check_bit("game", game, 1'b1);
		finish_test("reset");

		for (int i = 0; i < steps.size(); i++) begin
			run_step(steps[i]);
			t = steps[i].ctype;
			finish_test($sformatf("row %0d %s", i, t.name()));
		end

		epyx_discharge();

		$display("%0d tests, %0d passed, %0d failed", test_count, test_count - fail_count,
			fail_count);
		if (fail_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- list.f
design/cart_pkg.sv
design/io_strobe.sv
design/fastload_timer.sv
design/mapper_control.sv
design/addr_translate.sv
design/cart_top.sv
bench/cart_sva.sv
bench/cart_tb.sv

//--- Makefile
TOP = cart_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f list.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
